// File: hpm_cfg.svh
/*
 * Sizes, FIFO depths and CSR base addresses
 * for the performance-monitor unit
 */
`ifndef HPM_CFG_SVH
`define HPM_CFG_SVH

// Counter bank shape
`define HPM_NUM_COUNTERS 6
`define HPM_NR_COMMIT    2
`define HPM_XLEN         32

// CSR queue depths, request depth is also the initial host credit
`define HPM_REQ_DEPTH 4
`define HPM_RSP_DEPTH 4

// CSR bases for counter 3 onward
`define HPM_CSR_MCNT  12'hB03  // mhpmcounter3
`define HPM_CSR_MCNTH 12'hB83  // mhpmcounter3h
`define HPM_CSR_MEVT  12'h323  // mhpmevent3
`define HPM_CSR_CNT   12'hC03  // hpmcounter3, read only
`define HPM_CSR_CNTH  12'hC83  // hpmcounter3h, read only

`endif

// File: hpm_pkg.sv
/*
 * Shared types of the performance-monitor unit
 * Functional unit and operation enums, event codes, event vector, CSR address
 */
package hpm_pkg;

  // Functional unit of a committed instruction
  typedef enum logic [2:0] {
    NONE,
    LOAD,
    STORE,
    ALU,
    CTRL_FLOW,
    MULT,
    CSR,
    FPU
  } fu_e;

  // Only the ops needed for call and return detection
  typedef enum logic [1:0] {
    OP_ADD,
    OP_JALR,
    OP_OTHER
  } op_e;

  // Event selector codes, value is the bit position in the event vector
  typedef enum logic [4:0] {
    EV_NONE        = 5'd0,
    EV_ICACHE_MISS = 5'd1,
    EV_DCACHE_MISS = 5'd2,
    EV_ITLB_MISS   = 5'd3,
    EV_DTLB_MISS   = 5'd4,
    EV_LOAD        = 5'd5,
    EV_STORE       = 5'd6,
    EV_EXCEPTION   = 5'd7,
    EV_ERET        = 5'd8,
    EV_BRANCH      = 5'd9,
    EV_MISPREDICT  = 5'd10,
    EV_CALL        = 5'd11,
    EV_RETURN      = 5'd12,
    EV_SB_FULL     = 5'd13,
    EV_IF_EMPTY    = 5'd14,
    EV_INT         = 5'd15,
    EV_FP          = 5'd16,
    EV_STALL_ISSUE = 5'd17
  } hpm_event_e;

  localparam int unsigned HPM_NUM_EVENTS = 18;

  // Bit 0 (EV_NONE) never set
  typedef logic [HPM_NUM_EVENTS-1:0] event_vec_t;

  typedef logic [11:0] csr_addr_t;

endpackage

// File: hpm_fifo.sv
/*
 * Synchronous FIFO with a type parameter for the payload
 */
`timescale 1ns/1ps

module hpm_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [PW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CW-1:0] cnt_q;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CW'(DEPTH));
  assign data_o  = mem[rd_ptr_q];  // Head is visible before the pop

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Callers rely on credits, so overflow or underflow means a protocol bug upstream
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o));
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_o));

endmodule

// File: hpm_commit_decode.sv
/*
 * Pipeline stage 1
 * Classifies committed instructions and raw core events into a registered event vector
 */
`timescale 1ns/1ps
`include "hpm_cfg.svh"

module hpm_commit_decode (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                 [`HPM_NR_COMMIT-1:0] commit_ack_i,
  input  hpm_pkg::fu_e         [`HPM_NR_COMMIT-1:0] commit_fu_i,
  input  hpm_pkg::op_e         [`HPM_NR_COMMIT-1:0] commit_op_i,
  input  logic [`HPM_NR_COMMIT-1:0][4:0]           commit_rd_i,
  input  logic                                    icache_miss_i,
  input  logic                                    dcache_miss_i,
  input  logic                                    itlb_miss_i,
  input  logic                                    dtlb_miss_i,
  input  logic                                    exception_i,
  input  logic                                    eret_i,
  input  logic                                    mispredict_i,
  input  logic                                    sb_full_i,
  input  logic                                    if_empty_i,
  input  logic                                    stall_issue_i,
  input  logic                                    debug_mode_i,
  output hpm_pkg::event_vec_t                     event_vec_o,
  output logic                                    debug_o
);
  import hpm_pkg::*;

  logic [`HPM_NR_COMMIT-1:0] load_p, store_p, branch_p, call_p, ret_p, int_p, fp_p;
  event_vec_t                ev_d, ev_q;
  logic                      debug_q;

  // Per commit port classification
  always_comb begin
    for (int p = 0; p < `HPM_NR_COMMIT; p++) begin
      load_p[p]   = commit_ack_i[p] && (commit_fu_i[p] == LOAD);
      store_p[p]  = commit_ack_i[p] && (commit_fu_i[p] == STORE);
      branch_p[p] = commit_ack_i[p] && (commit_fu_i[p] == CTRL_FLOW);
      // Link register x1 or x5 marks a call, jal decodes as add
      call_p[p]   = commit_ack_i[p] && (commit_fu_i[p] == CTRL_FLOW) &&
                    (commit_op_i[p] == OP_ADD || commit_op_i[p] == OP_JALR) &&
                    (commit_rd_i[p] == 5'd1 || commit_rd_i[p] == 5'd5);
      ret_p[p]    = commit_ack_i[p] && (commit_op_i[p] == OP_JALR) && (commit_rd_i[p] == 5'd0);
      int_p[p]    = commit_ack_i[p] && (commit_fu_i[p] == ALU || commit_fu_i[p] == MULT);
      fp_p[p]     = commit_ack_i[p] && (commit_fu_i[p] == FPU);
    end
  end

  always_comb begin
    ev_d                 = '0;
    ev_d[EV_ICACHE_MISS] = icache_miss_i;
    ev_d[EV_DCACHE_MISS] = dcache_miss_i;
    ev_d[EV_ITLB_MISS]   = itlb_miss_i;
    ev_d[EV_DTLB_MISS]   = dtlb_miss_i;
    ev_d[EV_LOAD]        = |load_p;   // At most one count per cycle
    ev_d[EV_STORE]       = |store_p;
    ev_d[EV_EXCEPTION]   = exception_i;
    ev_d[EV_ERET]        = eret_i;
    ev_d[EV_BRANCH]      = |branch_p;
    ev_d[EV_MISPREDICT]  = mispredict_i;
    ev_d[EV_CALL]        = |call_p;
    ev_d[EV_RETURN]      = |ret_p;
    ev_d[EV_SB_FULL]     = sb_full_i;
    ev_d[EV_IF_EMPTY]    = if_empty_i;
    ev_d[EV_INT]         = |int_p;
    ev_d[EV_FP]          = |fp_p;
    ev_d[EV_STALL_ISSUE] = stall_issue_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ev_q    <= '0;
      debug_q <= 1'b0;
    end else begin
      ev_q    <= ev_d;
      debug_q <= debug_mode_i;  // Stays aligned with the events
    end
  end

  assign event_vec_o = ev_q;
  assign debug_o     = debug_q;

endmodule

// File: hpm_csr_port.sv
/*
 * CSR access front end with credit-based request and response channels
 * Request and response queues around the counter bank access
 */
`timescale 1ns/1ps
`include "hpm_cfg.svh"

module hpm_csr_port (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Host side
  input  logic                     req_valid_i,
  input  logic                     req_we_i,
  input  hpm_pkg::csr_addr_t       req_addr_i,
  input  logic [`HPM_XLEN-1:0]     req_wdata_i,
  output logic                     req_credit_o,
  output logic                     rsp_valid_o,
  output logic [`HPM_XLEN-1:0]     rsp_rdata_o,
  output logic                     rsp_err_o,
  input  logic                     rsp_credit_i,
  // Counter bank side
  output logic                     acc_valid_o,
  output logic                     acc_we_o,
  output hpm_pkg::csr_addr_t       acc_addr_o,
  output logic [`HPM_XLEN-1:0]     acc_wdata_o,
  input  logic [`HPM_XLEN-1:0]     acc_rdata_i,
  input  logic                     acc_err_i
);
  import hpm_pkg::*;

  typedef struct packed {
    logic                 we;
    csr_addr_t            addr;
    logic [`HPM_XLEN-1:0] wdata;
  } req_t;

  typedef struct packed {
    logic                 err;
    logic [`HPM_XLEN-1:0] rdata;
  } rsp_t;

  localparam int unsigned CW = $clog2(`HPM_RSP_DEPTH + 1);

  req_t          req_in, req_head;
  rsp_t          rsp_in, rsp_head;
  logic          req_empty, rsp_empty, rsp_full;
  logic          exec, send;
  logic [CW-1:0] credit_q;

  assign req_in = '{we: req_we_i, addr: req_addr_i, wdata: req_wdata_i};

  hpm_fifo #(.payload_t(req_t), .DEPTH(`HPM_REQ_DEPTH)) i_req_fifo (
    .clk_i, .rst_ni,
    .push_i(req_valid_i), .data_i(req_in),
    .pop_i(exec), .data_o(req_head),
    .empty_o(req_empty), .full_o()
  );

  // Execute only if the answer has somewhere to go
  assign exec         = !req_empty && !rsp_full;
  assign req_credit_o = exec;

  assign acc_valid_o = exec;
  assign acc_we_o    = req_head.we;
  assign acc_addr_o  = req_head.addr;
  assign acc_wdata_o = req_head.wdata;

  assign rsp_in = '{err: acc_err_i, rdata: acc_rdata_i};

  hpm_fifo #(.payload_t(rsp_t), .DEPTH(`HPM_RSP_DEPTH)) i_rsp_fifo (
    .clk_i, .rst_ni,
    .push_i(exec), .data_i(rsp_in),
    .pop_i(send), .data_o(rsp_head),
    .empty_o(rsp_empty), .full_o(rsp_full)
  );

  assign send        = (credit_q != '0) && !rsp_empty;
  assign rsp_valid_o = send;
  assign rsp_rdata_o = rsp_head.rdata;
  assign rsp_err_o   = rsp_head.err;

  // Response credits held by the port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CW'(`HPM_RSP_DEPTH);
    end else begin
      case ({rsp_credit_i, send})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Host never returns more credits than responses it received
  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CW'(`HPM_RSP_DEPTH));

endmodule

// File: hpm_counter_bank.sv
/*
 * Pipeline stage 2
 * Programmable 64-bit event counters with selectors and CSR read and write decode
 */
`timescale 1ns/1ps
`include "hpm_cfg.svh"

module hpm_counter_bank (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  hpm_pkg::event_vec_t  event_vec_i,
  input  logic                 debug_i,
  input  logic [31:0]          mcountinhibit_i,
  input  logic                 acc_valid_i,
  input  logic                 acc_we_i,
  input  hpm_pkg::csr_addr_t   acc_addr_i,
  input  logic [`HPM_XLEN-1:0] acc_wdata_i,
  output logic [`HPM_XLEN-1:0] acc_rdata_o,
  output logic                 acc_err_o
);
  import hpm_pkg::*;

  localparam int unsigned N  = `HPM_NUM_COUNTERS;
  localparam int unsigned XL = `HPM_XLEN;

  // Address range matches, one bit per counter
  logic [N-1:0] m_lo, m_hi, m_sel, m_clo, m_chi;
  logic [N-1:0] wr_lo, wr_hi, wr_sel, cnt_en;
  logic         hit, ro_write, acc_wr;

  logic [N-1:0][2*XL-1:0] cnt_val;
  logic [N-1:0][4:0]      sel_val;
  logic [XL-1:0]          rdata;

  always_comb begin
    for (int k = 0; k < N; k++) begin
      m_lo[k]  = (acc_addr_i == csr_addr_t'(`HPM_CSR_MCNT + k));
      m_hi[k]  = (acc_addr_i == csr_addr_t'(`HPM_CSR_MCNTH + k));
      m_sel[k] = (acc_addr_i == csr_addr_t'(`HPM_CSR_MEVT + k));
      m_clo[k] = (acc_addr_i == csr_addr_t'(`HPM_CSR_CNT + k));
      m_chi[k] = (acc_addr_i == csr_addr_t'(`HPM_CSR_CNTH + k));
    end
  end

  assign hit      = |{m_lo, m_hi, m_sel, m_clo, m_chi};
  assign ro_write = acc_we_i && |{m_clo, m_chi};  // Mirrors are read only
  assign acc_err_o = acc_valid_i && (!hit || ro_write);

  assign acc_wr = acc_valid_i && acc_we_i;
  assign wr_lo  = acc_wr ? m_lo : '0;
  assign wr_hi  = acc_wr ? m_hi : '0;
  assign wr_sel = acc_wr ? m_sel : '0;

  // Read mux, at most one range bit is set
  always_comb begin
    rdata = '0;
    for (int k = 0; k < N; k++) begin
      if (m_lo[k] || m_clo[k]) begin
        rdata = cnt_val[k][XL-1:0];
      end
      if (m_hi[k] || m_chi[k]) begin
        rdata = cnt_val[k][2*XL-1:XL];
      end
      if (m_sel[k]) begin
        rdata = XL'(sel_val[k]);  // Zero extended
      end
    end
  end

  assign acc_rdata_o = (acc_valid_i && !acc_err_o) ? rdata : '0;

  for (genvar k = 0; k < N; k++) begin : g_cnt
    logic [2*XL-1:0] cnt_q;
    logic [4:0]      sel_q;
    logic            ev_hit;

    // Codes past the last event are kept but never count
    assign ev_hit = (sel_q < 5'(HPM_NUM_EVENTS)) ? event_vec_i[sel_q] : 1'b0;

    // Counter k maps to hpmcounter k+3 and its inhibit bit
    assign cnt_en[k] = ev_hit && !debug_i && !mcountinhibit_i[k+3] && !wr_lo[k] && !wr_hi[k];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
        sel_q <= '0;
      end else begin
        if (wr_lo[k]) begin
          cnt_q[XL-1:0] <= acc_wdata_i;
        end
        if (wr_hi[k]) begin
          cnt_q[2*XL-1:XL] <= acc_wdata_i;
        end
        if (cnt_en[k]) begin
          cnt_q <= cnt_q + 1'b1;
        end
        if (wr_sel[k]) begin
          sel_q <= acc_wdata_i[4:0];
        end
      end
    end

    assign cnt_val[k] = cnt_q;
    assign sel_val[k] = sel_q;
  end

  // Error only reported with an access in flight from the port
  a_err_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_err_o |-> acc_valid_i);

endmodule

// File: hpm_top.sv
/*
 * Performance-monitor unit top level
 * Commit decode, CSR port and counter bank
 */
`timescale 1ns/1ps
`include "hpm_cfg.svh"

module hpm_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Core commit and event inputs
  input  logic                [`HPM_NR_COMMIT-1:0] commit_ack_i,
  input  hpm_pkg::fu_e        [`HPM_NR_COMMIT-1:0] commit_fu_i,
  input  hpm_pkg::op_e        [`HPM_NR_COMMIT-1:0] commit_op_i,
  input  logic [`HPM_NR_COMMIT-1:0][4:0]          commit_rd_i,
  input  logic                                   icache_miss_i,
  input  logic                                   dcache_miss_i,
  input  logic                                   itlb_miss_i,
  input  logic                                   dtlb_miss_i,
  input  logic                                   exception_i,
  input  logic                                   eret_i,
  input  logic                                   mispredict_i,
  input  logic                                   sb_full_i,
  input  logic                                   if_empty_i,
  input  logic                                   stall_issue_i,
  input  logic                                   debug_mode_i,
  input  logic [31:0]                            mcountinhibit_i,
  // Host CSR channels
  input  logic                                   req_valid_i,
  input  logic                                   req_we_i,
  input  hpm_pkg::csr_addr_t                     req_addr_i,
  input  logic [`HPM_XLEN-1:0]                   req_wdata_i,
  output logic                                   req_credit_o,
  output logic                                   rsp_valid_o,
  output logic [`HPM_XLEN-1:0]                   rsp_rdata_o,
  output logic                                   rsp_err_o,
  input  logic                                   rsp_credit_i
);
  import hpm_pkg::*;

  event_vec_t           event_vec;
  logic                 debug_q;
  logic                 acc_valid, acc_we, acc_err;
  csr_addr_t            acc_addr;
  logic [`HPM_XLEN-1:0] acc_wdata, acc_rdata;

  hpm_commit_decode i_decode (
    .clk_i, .rst_ni,
    .commit_ack_i, .commit_fu_i, .commit_op_i, .commit_rd_i,
    .icache_miss_i, .dcache_miss_i, .itlb_miss_i, .dtlb_miss_i,
    .exception_i, .eret_i, .mispredict_i, .sb_full_i, .if_empty_i, .stall_issue_i,
    .debug_mode_i,
    .event_vec_o(event_vec), .debug_o(debug_q)
  );

  hpm_csr_port i_port (
    .clk_i, .rst_ni,
    .req_valid_i, .req_we_i, .req_addr_i, .req_wdata_i, .req_credit_o,
    .rsp_valid_o, .rsp_rdata_o, .rsp_err_o, .rsp_credit_i,
    .acc_valid_o(acc_valid), .acc_we_o(acc_we), .acc_addr_o(acc_addr),
    .acc_wdata_o(acc_wdata), .acc_rdata_i(acc_rdata), .acc_err_i(acc_err)
  );

  hpm_counter_bank i_bank (
    .clk_i, .rst_ni,
    .event_vec_i(event_vec), .debug_i(debug_q), .mcountinhibit_i,
    .acc_valid_i(acc_valid), .acc_we_i(acc_we), .acc_addr_i(acc_addr),
    .acc_wdata_i(acc_wdata), .acc_rdata_o(acc_rdata), .acc_err_o(acc_err)
  );

endmodule

// File: tb_hpm.sv
/*
 * Testbench for the performance-monitor unit
 * Random events and CSR traffic checked against a counter model and an in-order host model
 */
`timescale 1ns/1ps
`include "hpm_cfg.svh"

module tb_hpm;
  import hpm_pkg::*;

  localparam int unsigned N              = `HPM_NUM_COUNTERS;
  localparam int unsigned NUM_OPS        = 850;  // CSR accesses plus event cycles, rounded up
  localparam int unsigned TIMEOUT_CYCLES = NUM_OPS * 40 + 2000;

  logic                            clk_i, rst_ni;
  logic [`HPM_NR_COMMIT-1:0]       commit_ack;
  fu_e  [`HPM_NR_COMMIT-1:0]       commit_fu;
  op_e  [`HPM_NR_COMMIT-1:0]       commit_op;
  logic [`HPM_NR_COMMIT-1:0][4:0]  commit_rd;
  logic [9:0]                      raw_ev;  // icache, dcache, itlb, dtlb, exc, eret, mispr, sb, if, stall
  logic                            debug_mode;
  logic [31:0]                     mcountinhibit;
  logic                            req_valid, req_we, req_credit;
  csr_addr_t                       req_addr;
  logic [`HPM_XLEN-1:0]            req_wdata, rsp_rdata;
  logic                            rsp_valid, rsp_err, rsp_credit;

  // Reference model state
  logic [63:0] m_cnt [N];
  logic [4:0]  m_sel [N];
  event_vec_t  prev_ev;
  logic        prev_dbg;
  logic [32:0] exp_q [$];  // {err, data} in request order
  int unsigned spent, credits_back, received, returned;
  bit          slow_credits;

  hpm_top i_dut (
    .clk_i, .rst_ni,
    .commit_ack_i(commit_ack), .commit_fu_i(commit_fu), .commit_op_i(commit_op),
    .commit_rd_i(commit_rd),
    .icache_miss_i(raw_ev[0]), .dcache_miss_i(raw_ev[1]), .itlb_miss_i(raw_ev[2]),
    .dtlb_miss_i(raw_ev[3]), .exception_i(raw_ev[4]), .eret_i(raw_ev[5]),
    .mispredict_i(raw_ev[6]), .sb_full_i(raw_ev[7]), .if_empty_i(raw_ev[8]),
    .stall_issue_i(raw_ev[9]), .debug_mode_i(debug_mode), .mcountinhibit_i(mcountinhibit),
    .req_valid_i(req_valid), .req_we_i(req_we), .req_addr_i(req_addr),
    .req_wdata_i(req_wdata), .req_credit_o(req_credit),
    .rsp_valid_o(rsp_valid), .rsp_rdata_o(rsp_rdata), .rsp_err_o(rsp_err),
    .rsp_credit_i(rsp_credit)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0d ns: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort(input string why);
    $display("Error at %0d ns: %s", $time, why);
    $display("Result: FAILED");
    $fatal(1, "protocol error");
  endtask

  // Event vector straight from the classification rules
  function automatic event_vec_t classify(input logic [`HPM_NR_COMMIT-1:0] ack,
                                          input fu_e [`HPM_NR_COMMIT-1:0] fu,
                                          input op_e [`HPM_NR_COMMIT-1:0] op,
                                          input logic [`HPM_NR_COMMIT-1:0][4:0] rd,
                                          input logic [9:0] r);
    event_vec_t ev;
    ev = '0;
    for (int p = 0; p < `HPM_NR_COMMIT; p++) begin
      if (ack[p]) begin
        if (fu[p] == LOAD) ev[5] = 1'b1;
        if (fu[p] == STORE) ev[6] = 1'b1;
        if (fu[p] == CTRL_FLOW) ev[9] = 1'b1;
        if (fu[p] == CTRL_FLOW && (op[p] == OP_ADD || op[p] == OP_JALR) &&
            (rd[p] == 5'd1 || rd[p] == 5'd5)) ev[11] = 1'b1;
        if (op[p] == OP_JALR && rd[p] == 5'd0) ev[12] = 1'b1;
        if (fu[p] == ALU || fu[p] == MULT) ev[15] = 1'b1;
        if (fu[p] == FPU) ev[16] = 1'b1;
      end
    end
    {ev[17], ev[14], ev[13], ev[10], ev[8], ev[7]} = r[9:4];
    ev[4:1] = r[3:0];
    return ev;
  endfunction

  // One event cycle, random or idle, with optional inhibit and debug traffic
  task automatic step(input bit rnd, input bit ctl);
    logic [`HPM_NR_COMMIT-1:0]      ack;
    fu_e  [`HPM_NR_COMMIT-1:0]      fu;
    op_e  [`HPM_NR_COMMIT-1:0]      op;
    logic [`HPM_NR_COMMIT-1:0][4:0] rd;
    logic [9:0]                     r;
    logic                           dbg;
    logic [31:0]                    inh;
    int unsigned                    pick;
    for (int p = 0; p < `HPM_NR_COMMIT; p++) begin
      ack[p] = 1'b0;
      fu[p]  = NONE;
      op[p]  = OP_OTHER;
      rd[p]  = 5'd0;
      if (rnd) begin
        ack[p] = 1'($urandom_range(0, 1));
        fu[p]  = fu_e'($urandom_range(0, 7));
        op[p]  = op_e'($urandom_range(0, 2));
        pick   = $urandom_range(0, 3);  // Bias towards link registers
        rd[p]  = (pick == 0) ? 5'd0 : (pick == 1) ? 5'd1 : (pick == 2) ? 5'd5 :
                 5'($urandom_range(0, 31));
      end
    end
    r   = rnd ? 10'($urandom) : '0;
    dbg = ctl ? ($urandom_range(0, 3) == 0) : 1'b0;
    inh = ctl ? $urandom : '0;
    @(posedge clk_i);
    commit_ack    <= ack;
    commit_fu     <= fu;
    commit_op     <= op;
    commit_rd     <= rd;
    raw_ev        <= r;
    debug_mode    <= dbg;
    mcountinhibit <= inh;
    req_valid     <= 1'b0;
    // Bank sees last cycle's events with this cycle's inhibit
    for (int k = 0; k < N; k++) begin
      if (!prev_dbg && !inh[k+3] && m_sel[k] < 5'd18 && prev_ev[m_sel[k]]) begin
        m_cnt[k] = m_cnt[k] + 1;
      end
    end
    prev_ev  = classify(ack, fu, op, rd, r);
    prev_dbg = dbg;
  endtask

  task automatic burst(input int len, input bit ctl);
    repeat (len) step(1'b1, ctl);
    repeat (2) step(1'b0, 1'b0);  // Let the pipeline drain
  endtask

  // Issue one CSR access once a request credit is held, expected answer from the model
  task automatic csr_access(input bit we, input csr_addr_t addr, input logic [31:0] wdata);
    logic        err;
    logic [31:0] data;
    err  = 1'b1;
    data = '0;
    for (int k = 0; k < N; k++) begin
      if (addr == csr_addr_t'(`HPM_CSR_MCNT + k)) begin
        err  = 1'b0;
        data = m_cnt[k][31:0];
        if (we) m_cnt[k][31:0] = wdata;
      end else if (addr == csr_addr_t'(`HPM_CSR_MCNTH + k)) begin
        err  = 1'b0;
        data = m_cnt[k][63:32];
        if (we) m_cnt[k][63:32] = wdata;
      end else if (addr == csr_addr_t'(`HPM_CSR_MEVT + k)) begin
        err  = 1'b0;
        data = {27'd0, m_sel[k]};
        if (we) m_sel[k] = wdata[4:0];
      end else if (addr == csr_addr_t'(`HPM_CSR_CNT + k)) begin
        err  = we;
        data = we ? '0 : m_cnt[k][31:0];
      end else if (addr == csr_addr_t'(`HPM_CSR_CNTH + k)) begin
        err  = we;
        data = we ? '0 : m_cnt[k][63:32];
      end
    end
    @(posedge clk_i);
    while (`HPM_REQ_DEPTH + credits_back - spent == 0) begin
      req_valid <= 1'b0;
      @(posedge clk_i);
    end
    req_valid <= 1'b1;
    req_we    <= we;
    req_addr  <= addr;
    req_wdata <= wdata;
    spent++;
    exp_q.push_back({err, data});
  endtask

  task automatic drain();
    @(posedge clk_i);
    req_valid <= 1'b0;
    while (exp_q.size() != 0 || received != returned) @(posedge clk_i);
    check("request credits returned", 64'(credits_back), 64'(spent));
  endtask

  task automatic read_all();
    for (int k = 0; k < N; k++) begin
      csr_access(1'b0, csr_addr_t'(`HPM_CSR_MCNT + k), '0);
      csr_access(1'b0, csr_addr_t'(`HPM_CSR_MCNTH + k), '0);
      csr_access(1'b0, csr_addr_t'(`HPM_CSR_CNT + k), '0);
      csr_access(1'b0, csr_addr_t'(`HPM_CSR_CNTH + k), '0);
      csr_access(1'b0, csr_addr_t'(`HPM_CSR_MEVT + k), '0);
    end
  endtask

  // Host receive side, sampled mid-cycle where outputs are settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (req_credit) begin
        credits_back++;
        if (credits_back > spent) abort("request credit returned without a pending request");
      end
      if (rsp_valid) begin
        if (exp_q.size() == 0) abort("response arrived with no request outstanding");
        check("response data", 64'(rsp_rdata), 64'(exp_q[0][31:0]));
        check("response error", 64'(rsp_err), 64'(exp_q[0][32]));
        void'(exp_q.pop_front());
        received++;
        if (received - returned > `HPM_RSP_DEPTH) abort("more responses than response credits");
      end
    end
  end

  // Response credits go back after a random delay
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      rsp_credit <= 1'b0;
    end else if (received != returned && $urandom_range(0, slow_credits ? 9 : 1) == 0) begin
      rsp_credit <= 1'b1;
      returned++;
    end else begin
      rsp_credit <= 1'b0;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(32'h96da_90cc));
    rst_ni        = 1'b0;
    commit_ack    = '0;
    commit_fu     = '{NONE, NONE};
    commit_op     = '{OP_OTHER, OP_OTHER};
    commit_rd     = '0;
    raw_ev        = '0;
    debug_mode    = 1'b0;
    mcountinhibit = '0;
    req_valid     = 1'b0;
    req_we        = 1'b0;
    req_addr      = '0;
    req_wdata     = '0;
    rsp_credit    = 1'b0;
    prev_ev       = '0;
    prev_dbg      = 1'b0;
    slow_credits  = 1'b0;
    for (int k = 0; k < N; k++) begin
      m_cnt[k] = '0;
      m_sel[k] = '0;
    end
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset values, monitor flags any early response or credit
    repeat (10) step(1'b0, 1'b0);
    read_all();
    drain();

    // Programmed selectors, then plain and gated bursts
    for (int k = 0; k < N; k++) csr_access(1'b1, csr_addr_t'(`HPM_CSR_MEVT + k),
                                           32'($urandom_range(0, 17)));
    drain();
    repeat (3) begin
      burst(40, 1'b0);
      read_all();
      drain();
    end
    repeat (3) begin
      burst(40, 1'b1);
      read_all();
      drain();
    end

    // Written halves, counter 0 watches icache misses to force a carry
    for (int k = 0; k < N; k++) begin
      csr_access(1'b1, csr_addr_t'(`HPM_CSR_MCNT + k), 32'hFFFF_FFFF);
      csr_access(1'b1, csr_addr_t'(`HPM_CSR_MCNTH + k), $urandom);
      csr_access(1'b1, csr_addr_t'(`HPM_CSR_MEVT + k), (k == 0) ? 32'd1 :
                 32'($urandom_range(0, 17)));
    end
    drain();
    read_all();
    drain();
    burst(30, 1'b0);
    read_all();
    drain();

    // Error cases and an out of range selector code
    for (int k = 0; k < N; k++) begin
      csr_access(1'b1, csr_addr_t'(`HPM_CSR_CNT + k), $urandom);
      csr_access(1'b1, csr_addr_t'(`HPM_CSR_CNTH + k), $urandom);
    end
    csr_access(1'b0, csr_addr_t'(`HPM_CSR_MCNT + N), '0);
    csr_access(1'b1, csr_addr_t'(`HPM_CSR_MEVT + N), 32'd3);
    csr_access(1'b0, 12'h000, '0);
    csr_access(1'b0, 12'hB02, '0);
    csr_access(1'b1, csr_addr_t'(`HPM_CSR_MEVT + 2), 32'(18 + $urandom_range(0, 13)));
    drain();
    burst(30, 1'b0);
    read_all();
    drain();

    // Back pressure from slow response credits
    slow_credits = 1'b1;
    repeat (5) read_all();
    drain();
    slow_credits = 1'b0;

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: hpm.f
+incdir+.
hpm_pkg.sv
hpm_fifo.sv
hpm_commit_decode.sv
hpm_csr_port.sv
hpm_counter_bank.sv
hpm_top.sv
tb_hpm.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the performance-monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing -j 0 -Wno-fatal -f hpm.f --top-module tb_hpm -o sim_hpm

# The simulator status is masked by tee, the log decides
./obj_dir/sim_hpm | tee sim.log || true

if grep -q "Result: PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
